// ==== logic/lpcPkg.sv ====
`default_nettype none

// --------------------
// LPC protocol codes
// --------------------
package lpcPkg;

    typedef logic [3:0] lpcNibbleT;                 // One LAD transfer

    localparam lpcNibbleT LpcStart     = 4'b0000;   // Start of target cycle
    localparam lpcNibbleT LpcIoRead    = 4'b0000;   // I/O, host reads
    localparam lpcNibbleT LpcIoWrite   = 4'b0010;   // I/O, host writes
    localparam lpcNibbleT LpcSyncReady = 4'b0000;   // Ready, no wait states
    localparam lpcNibbleT LpcTarIdle   = 4'b1111;   // Turnaround value

    // Target cycle states, host side first, then target side
    typedef enum logic [3:0] {
        StIdle,         // Waiting for start
        StCycType,      // Cycle type and direction
        StAddr3,        // Address [15:12]
        StAddr2,        // Address [11:8]
        StAddr1,        // Address [7:4]
        StAddr0,        // Address [3:0]
        StWrData0,      // Write data low nibble
        StWrData1,      // Write data high nibble
        StHostTar,      // Host turnaround, two clocks
        StSync,         // Target drives sync
        StRdData0,      // Read data low nibble
        StRdData1,      // Read data high nibble
        StTarTurn       // Target turnaround
    } lpcStateT;

endpackage

`default_nettype wire

// ==== logic/regPkg.sv ====
`default_nettype none

// --------------------
// CPLD register map
// --------------------
package regPkg;

    typedef logic [7:0] regByteT;               // Register contents
    typedef logic [7:0] regAddrT;               // Offset inside the I/O page

    localparam regByteT CpldIoPage = 8'h0A;     // Claims 0x0A00 to 0x0AFF

    localparam regAddrT PostCodeAddr  = 8'h80;  // POST code port
    localparam regAddrT BiosCtrlAddr  = 8'h01;  // Dual BIOS control
    localparam regAddrT WdtCountAddr  = 8'h02;  // BIOS watchdog count
    localparam regAddrT IntStatusAddr = 8'h09;  // Interrupt status and mask

    // BiosCtrlAddr bits
    localparam int BiosSwapBit   = 0;           // Software swap, R/W
    localparam int BiosJumperBit = 1;           // Jumper level, RO
    localparam int BiosActiveBit = 2;           // Flash in use, RO

    // IntStatusAddr bits
    localparam int IntPendBit = 0;              // Watchdog pending, write 1 clears
    localparam int IntMaskBit = 1;              // Watchdog interrupt enable

    // Watchdog tick, kept short for simulation
    localparam int WdtTickCycles = 64;
    localparam int WdtPreWidth   = $clog2(WdtTickCycles);

endpackage

`default_nettype wire

// ==== logic/regBusIf.sv ====
`timescale 1ns/1ns
`default_nettype none

// Register access from the LPC target into the register file
interface regBusIf import regPkg::*; ();

    logic    wr;        // One-cycle write strobe
    logic    rd;        // One-cycle read strobe
    regAddrT addr;      // Offset in the CPLD page
    regByteT wrData;    // Byte to write
    regByteT rdData;    // Answer in the same cycle

    // LPC side
    modport host (
        output wr, rd, addr, wrData,
        input  rdData
    );

    // Register file side
    modport dev (
        input  wr, rd, addr, wrData,
        output rdData
    );

endinterface

`default_nettype wire

// ==== logic/lpcTarget.sv ====
`timescale 1ns/1ns
`default_nettype none

module lpcTarget import lpcPkg::*, regPkg::*; (
    input  wire logic      LpcClock,
    input  wire logic      rstN,
    input  wire logic      lpcFrameN,
    input  wire lpcNibbleT lpcLadIn,
    output lpcNibbleT      lpcLadOut,
    output logic           lpcLadOe,
    regBusIf.host          regBus
);

    lpcStateT state;
    lpcStateT stateNext;
    logic     isWrite;      // Latched from the cycle type nibble
    logic     tarSecond;    // Second clock of host turnaround
    logic     claimed;      // Upper address byte hits our page
    regByteT  addrHi;
    regAddrT  addrLo;
    regByteT  wrByte;
    regByteT  rdByte;       // Read data held for the data phase

    assign claimed = (addrHi == CpldIoPage);

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        stateNext = state;
        if (!lpcFrameN) begin
            // Frame low aborts anything in flight
            stateNext = (lpcLadIn == LpcStart) ? StCycType : StIdle;
        end else begin
            case (state)
                StIdle:    stateNext = StIdle;
                StCycType: begin
                    if (lpcLadIn == LpcIoRead || lpcLadIn == LpcIoWrite) begin
                        stateNext = StAddr3;
                    end else begin
                        stateNext = StIdle;     // Memory, DMA, FWH ignored
                    end
                end
                StAddr3:   stateNext = StAddr2;
                StAddr2:   stateNext = StAddr1;
                StAddr1:   stateNext = StAddr0;
                StAddr0:   stateNext = isWrite ? StWrData0 : StHostTar;
                StWrData0: stateNext = StWrData1;
                StWrData1: stateNext = StHostTar;
                StHostTar: begin
                    if (tarSecond) begin
                        stateNext = claimed ? StSync : StIdle;  // Foreign page stays off the bus
                    end
                end
                StSync:    stateNext = isWrite ? StTarTurn : StRdData0;
                StRdData0: stateNext = StRdData1;
                StRdData1: stateNext = StTarTurn;
                StTarTurn: stateNext = StIdle;
                default:   stateNext = StIdle;
            endcase
        end
    end

    // --------------------
    // Control registers
    // --------------------
    always_ff @(posedge LpcClock) begin
        if (!rstN) begin
            state     <= StIdle;
            isWrite   <= 1'b0;
            tarSecond <= 1'b0;
            lpcLadOe  <= 1'b0;
        end else begin
            state     <= stateNext;
            tarSecond <= (state == StHostTar) && !tarSecond;    // Counts the two TAR clocks
            // Enable lines up with the states that drive LAD
            lpcLadOe  <= stateNext inside {StSync, StRdData0, StRdData1, StTarTurn};
            if (state == StCycType) begin
                isWrite <= (lpcLadIn == LpcIoWrite);
            end
        end
    end

    // Address and data capture
    always_ff @(posedge LpcClock) begin
        case (state)
            StAddr3:   addrHi[7:4] <= lpcLadIn;     // MSN first
            StAddr2:   addrHi[3:0] <= lpcLadIn;
            StAddr1:   addrLo[7:4] <= lpcLadIn;
            StAddr0:   addrLo[3:0] <= lpcLadIn;
            StWrData0: wrByte[3:0] <= lpcLadIn;     // Data LSN first
            StWrData1: wrByte[7:4] <= lpcLadIn;
            StSync:    rdByte      <= regBus.rdData;
            default:   ;
        endcase
    end

    // --------------------
    // Register bus
    // --------------------
    assign regBus.wr     = (state == StSync) && isWrite;   // Lands at end of sync
    assign regBus.rd     = (state == StSync) && !isWrite;
    assign regBus.addr   = addrLo;
    assign regBus.wrData = wrByte;

    // LAD drive value qualified by lpcLadOe
    always_comb begin
        case (state)
            StSync:    lpcLadOut = LpcSyncReady;
            StRdData0: lpcLadOut = rdByte[3:0];
            StRdData1: lpcLadOut = rdByte[7:4];
            default:   lpcLadOut = LpcTarIdle;
        endcase
    end

    // Only a cycle to our own page may drive LAD
    assert property (@(posedge LpcClock) disable iff (!rstN)
        lpcLadOe |-> claimed);

endmodule

`default_nettype wire

// ==== logic/cpldRegs.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpldRegs import regPkg::*; (
    input  wire logic LpcClock,
    input  wire logic rstN,
    regBusIf.dev      regBus,
    input  wire logic wdtExpire,
    input  wire logic biosActive,
    input  wire logic biosSwap,
    input  wire logic biosSel,
    output regByteT   postCode,
    output logic      wdtLoad,
    output regByteT   wdtValue,
    output logic      swapWr,
    output logic      swapValue,
    output logic      intN
);

    logic    postHit;
    logic    intHit;
    logic    intPend;       // Watchdog fired
    logic    intMask;       // Watchdog interrupt enabled
    regByteT wdtLast;       // Last count written for readback

    // --------------------
    // Write decode
    // --------------------
    assign postHit = regBus.wr && (regBus.addr == PostCodeAddr);
    assign intHit  = regBus.wr && (regBus.addr == IntStatusAddr);
    assign wdtLoad = regBus.wr && (regBus.addr == WdtCountAddr);   // Pulse to watchdog
    assign swapWr  = regBus.wr && (regBus.addr == BiosCtrlAddr);   // Pulse to BIOS switch

    assign wdtValue  = regBus.wrData;
    assign swapValue = regBus.wrData[BiosSwapBit];

    always_ff @(posedge LpcClock) begin
        if (!rstN) begin
            postCode <= '0;
            wdtLast  <= '0;
            intPend  <= 1'b0;
            intMask  <= 1'b0;
        end else begin
            if (postHit) begin
                postCode <= regBus.wrData;
            end
            if (wdtLoad) begin
                wdtLast <= regBus.wrData;
            end
            if (intHit) begin
                intMask <= regBus.wrData[IntMaskBit];
            end
            // Expiry beats a clear in the same clock
            if (wdtExpire) begin
                intPend <= 1'b1;
            end else if (intHit && regBus.wrData[IntPendBit]) begin
                intPend <= 1'b0;    // W1C
            end
        end
    end

    assign intN = ~(intPend & intMask);    // Active low to chipset

    // --------------------
    // Readback
    // --------------------
    always_comb begin
        regBus.rdData = '0;
        case (regBus.addr)
            PostCodeAddr: regBus.rdData = postCode;
            BiosCtrlAddr: begin
                regBus.rdData[BiosSwapBit]   = biosSwap;
                regBus.rdData[BiosJumperBit] = biosSel;
                regBus.rdData[BiosActiveBit] = biosActive;
            end
            WdtCountAddr: regBus.rdData = wdtLast;
            IntStatusAddr: begin
                regBus.rdData[IntPendBit] = intPend;
                regBus.rdData[IntMaskBit] = intMask;
            end
            default: ;
        endcase
    end

    // One LPC cycle is either a read or a write
    assert property (@(posedge LpcClock) disable iff (!rstN)
        !(regBus.wr && regBus.rd));

endmodule

`default_nettype wire

// ==== logic/biosWatchdog.sv ====
`timescale 1ns/1ns
`default_nettype none

module biosWatchdog import regPkg::*; (
    input  wire logic    LpcClock,
    input  wire logic    rstN,
    input  wire logic    wdtLoad,
    input  wire regByteT wdtValue,
    output logic         wdtExpire
);

    logic [WdtPreWidth-1:0] preCnt;
    logic                   tick;
    regByteT                count;      // Ticks left
    logic                   armed;

    // --------------------
    // Tick prescaler
    // --------------------
    assign tick = (preCnt == WdtPreWidth'(WdtTickCycles - 1));

    always_ff @(posedge LpcClock) begin
        if (!rstN) begin
            preCnt <= '0;
        end else begin
            preCnt <= tick ? '0 : preCnt + 1'b1;   // Free running
        end
    end

    // --------------------
    // Boot countdown
    // --------------------
    always_ff @(posedge LpcClock) begin
        if (!rstN) begin
            count     <= '0;
            armed     <= 1'b0;
            wdtExpire <= 1'b0;
        end else begin
            wdtExpire <= 1'b0;
            if (wdtLoad) begin
                count <= wdtValue;
                armed <= (wdtValue != '0);      // Zero means BIOS done
            end else if (armed && tick) begin
                count <= count - 1'b1;
                if (count == 8'd1) begin
                    armed     <= 1'b0;          // Fire once
                    wdtExpire <= 1'b1;
                end
            end
        end
    end

    // Expiry is a single-clock event
    assert property (@(posedge LpcClock) disable iff (!rstN)
        wdtExpire |=> !wdtExpire);

endmodule

`default_nettype wire

// ==== logic/biosSwitch.sv ====
`timescale 1ns/1ns
`default_nettype none

module biosSwitch (
    input  wire logic  LpcClock,
    input  wire logic  rstN,
    input  wire logic  swapWr,
    input  wire logic  swapValue,
    input  wire logic  wdtExpire,
    input  wire logic  biosSel,
    input  wire logic  spiCsN,
    output logic [1:0] biosCsN,
    output logic [1:0] biosLedN,
    output logic       biosActive,
    output logic       biosSwap
);

    // --------------------
    // Swap flag
    // --------------------
    always_ff @(posedge LpcClock) begin
        if (!rstN) begin
            biosSwap <= 1'b0;
        end else if (wdtExpire) begin
            biosSwap <= ~biosSwap;      // Failed boot moves to the other flash
        end else if (swapWr) begin
            biosSwap <= swapValue;
        end
    end

    assign biosActive = biosSel ^ biosSwap;    // Jumper picks default flash

    // --------------------
    // Chip select routing
    // --------------------
    assign biosCsN[0] = biosActive ? 1'b1 : spiCsN;    // Idle flash parked high
    assign biosCsN[1] = biosActive ? spiCsN : 1'b1;

    // LED on for the flash in use
    assign biosLedN[0] = biosActive;
    assign biosLedN[1] = ~biosActive;

endmodule

`default_nettype wire

// ==== logic/boardCpld.sv ====
`timescale 1ns/1ns
`default_nettype none

module boardCpld import lpcPkg::*, regPkg::*; (
    input  wire logic      LpcClock,
    input  wire logic      rstN,
    input  wire logic      lpcFrameN,
    input  wire lpcNibbleT lpcLadIn,
    output lpcNibbleT      lpcLadOut,   // Pad tristate sits outside
    output logic           lpcLadOe,
    input  wire logic      biosSel,     // BIOS select jumper
    input  wire logic      spiCsN,      // Chipset SPI CS
    output logic [1:0]     biosCsN,
    output logic [1:0]     biosLedN,
    output regByteT        postCode,
    output logic           intN         // To chipset
);

    regBusIf regBus ();

    logic    wdtLoad;
    regByteT wdtValue;
    logic    wdtExpire;
    logic    swapWr;
    logic    swapValue;
    logic    biosActive;
    logic    biosSwap;

    // --------------------
    // Host access
    // --------------------
    lpcTarget u_lpcTarget (
        .LpcClock  (LpcClock),
        .rstN      (rstN),
        .lpcFrameN (lpcFrameN),
        .lpcLadIn  (lpcLadIn),
        .lpcLadOut (lpcLadOut),
        .lpcLadOe  (lpcLadOe),
        .regBus    (regBus)
    );

    cpldRegs u_cpldRegs (
        .LpcClock   (LpcClock),
        .rstN       (rstN),
        .regBus     (regBus),
        .wdtExpire  (wdtExpire),
        .biosActive (biosActive),   // Readback only
        .biosSwap   (biosSwap),
        .biosSel    (biosSel),
        .postCode   (postCode),
        .wdtLoad    (wdtLoad),
        .wdtValue   (wdtValue),
        .swapWr     (swapWr),
        .swapValue  (swapValue),
        .intN       (intN)
    );

    // --------------------
    // Dual BIOS
    // --------------------
    biosWatchdog u_biosWatchdog (
        .LpcClock  (LpcClock),
        .rstN      (rstN),
        .wdtLoad   (wdtLoad),
        .wdtValue  (wdtValue),
        .wdtExpire (wdtExpire)
    );

    biosSwitch u_biosSwitch (
        .LpcClock   (LpcClock),
        .rstN       (rstN),
        .swapWr     (swapWr),
        .swapValue  (swapValue),
        .wdtExpire  (wdtExpire),
        .biosSel    (biosSel),
        .spiCsN     (spiCsN),
        .biosCsN    (biosCsN),
        .biosLedN   (biosLedN),
        .biosActive (biosActive),
        .biosSwap   (biosSwap)
    );

endmodule

`default_nettype wire

// ==== test/boardCpldTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module boardCpldTb import lpcPkg::*, regPkg::*; ();

    typedef logic [8*24-1:0] nameT;                 // Test name from the data file

    localparam string DataFile    = "test/boardCpldTestdata.txt";
    localparam int    ResetCycles = 4;
    localparam int    DriveDelay  = 1;              // ns after the rising edge
    localparam int    BusSlots    = 13;             // Start nibble to idle
    localparam int    WriteBudget = 13;             // Cycle budget per write
    localparam int    ReadBudget  = 15;             // Cycle budget per read
    localparam logic  JumperLevel = 1'b1;           // Flash 1 is the default
    localparam int    OpNone      = 0;
    localparam int    OpWrite     = 1;
    localparam int    OpRead      = 2;
    localparam int    OpPin       = 3;
    localparam int    OpWait      = 4;

    logic       LpcClock = 1'b0;
    logic       rstN;
    logic       lpcFrameN;
    lpcNibbleT  lpcLadIn;
    lpcNibbleT  lpcLadOut;
    logic       lpcLadOe;
    logic       biosSel;
    logic       spiCsN;
    logic [1:0] biosCsN;
    logic [1:0] biosLedN;
    regByteT    postCode;
    logic       intN;

    integer seed        = 80;
    integer randWord;
    int     valueErrors = 0;
    int     otherErrors = 0;
    int     cycleCount  = 0;
    int     cycleLimit  = 0;

    boardCpld u_boardCpld (
        .LpcClock  (LpcClock),
        .rstN      (rstN),
        .lpcFrameN (lpcFrameN),
        .lpcLadIn  (lpcLadIn),
        .lpcLadOut (lpcLadOut),
        .lpcLadOe  (lpcLadOe),
        .biosSel   (biosSel),
        .spiCsN    (spiCsN),
        .biosCsN   (biosCsN),
        .biosLedN  (biosLedN),
        .postCode  (postCode),
        .intN      (intN)
    );

    always #5 LpcClock = ~LpcClock;                 // 10 ns period

    // Run limit, twice the budget of the data file
    always @(posedge LpcClock) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not end within %0d clock cycles", cycleLimit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // --------------------
    // Helpers
    // --------------------
    task automatic clockStep();
        @(posedge LpcClock);
        #DriveDelay;                                // Outputs settled, inputs may change
    endtask

    task automatic driveBus(input logic frameN, input lpcNibbleT nibble);
        lpcFrameN = frameN;
        lpcLadIn  = nibble;
        randWord  = $random(seed);
        spiCsN    = randWord[0];                    // Chipset SPI select wanders
    endtask

    task automatic compareValue(input nameT testName, input logic [15:0] expected,
                                input logic [15:0] actual);
        if (actual !== expected) begin
            $display("error %0s: expected %h, actual %h", testName, expected, actual);
            valueErrors++;
        end
    endtask

    // Next operation line, comment and blank lines skipped
    task automatic readOp(input int fd, output int op, output logic [15:0] arg,
                          output logic [15:0] value, output nameT testName);
        logic [8*128-1:0] line;
        logic [8*8-1:0]   opTok;
        int               got;
        op       = OpNone;
        arg      = '0;
        value    = '0;
        testName = '0;
        while (op == OpNone && !$feof(fd)) begin
            line  = '0;
            opTok = '0;
            got   = $fgets(line, fd);
            if (got > 0 && $sscanf(line, "%s %h %h %s", opTok, arg, value, testName) == 4) begin
                if (opTok == "write") op = OpWrite;
                else if (opTok == "read") op = OpRead;
                else if (opTok == "pin") op = OpPin;
                else if (opTok == "wait") op = OpWait;
            end
        end
    endtask

    // --------------------
    // LPC I/O cycle
    // --------------------
    task automatic busCycle(input logic writeOp, input logic [15:0] ioAddr,
                            input regByteT wrByte, input nameT testName, output regByteT rdByte);
        lpcNibbleT hostNib [0:BusSlots-1];
        logic      claim;
        logic      expOe;
        int        syncSlot;
        int        oeSlots;
        claim = (ioAddr[15:8] == CpldIoPage);
        for (int i = 0; i < BusSlots; i++) begin
            hostNib[i] = LpcTarIdle;                // Turnaround and idle slots
        end
        hostNib[0] = LpcStart;
        hostNib[1] = writeOp ? LpcIoWrite : LpcIoRead;
        hostNib[2] = ioAddr[15:12];                 // MSN first
        hostNib[3] = ioAddr[11:8];
        hostNib[4] = ioAddr[7:4];
        hostNib[5] = ioAddr[3:0];
        if (writeOp) begin
            hostNib[6] = wrByte[3:0];               // Data LSN first
            hostNib[7] = wrByte[7:4];
        end
        syncSlot = writeOp ? 10 : 8;                // Two TAR slots after last host nibble
        oeSlots  = writeOp ? 2 : 4;
        rdByte   = '0;
        for (int slot = 0; slot < BusSlots; slot++) begin
            clockStep();
            expOe = claim && slot >= syncSlot && slot < syncSlot + oeSlots;
            if (lpcLadOe !== expOe) begin
                $display("%0s: lpcLadOe is %b in bus slot %0d where %b is expected",
                         testName, lpcLadOe, slot, expOe);
                otherErrors++;
            end
            if (claim && slot == syncSlot) compareValue(testName, 16'(LpcSyncReady), 16'(lpcLadOut));
            if (claim && !writeOp && slot == syncSlot + 1) rdByte[3:0] = lpcLadOut;
            if (claim && !writeOp && slot == syncSlot + 2) rdByte[7:4] = lpcLadOut;
            driveBus(slot == 0 ? 1'b0 : 1'b1, hostNib[slot]);
        end
    endtask

    // Pin codes: 0 postCode, 1 intN, 2 active flash index
    task automatic checkPin(input logic [15:0] pinCode, input logic [15:0] value,
                            input nameT testName);
        logic [1:0] expLed;
        logic [1:0] expCs;
        clockStep();
        expLed = value[0] ? 2'b01 : 2'b10;                          // Active LED low
        expCs  = value[0] ? {spiCsN, 1'b1} : {1'b1, spiCsN};        // Idle flash parked high
        case (pinCode)
            16'd0: compareValue(testName, value, 16'(postCode));
            16'd1: compareValue(testName, value, 16'(intN));
            16'd2: begin
                compareValue(testName, 16'(expLed), 16'(biosLedN));
                compareValue(testName, 16'(expCs), 16'(biosCsN));
            end
            default: begin
                $display("%0s: pin code %0d is not known", testName, pinCode);
                otherErrors++;
            end
        endcase
        driveBus(1'b1, LpcTarIdle);
    endtask

    // --------------------
    // Sequence
    // --------------------
    initial begin
        int          fd;
        int          op;
        int          budget;
        logic [15:0] arg;
        logic [15:0] value;
        nameT        testName;
        regByteT     rdByte;
        rstN      = 1'b0;
        lpcFrameN = 1'b1;
        lpcLadIn  = LpcTarIdle;
        biosSel   = JumperLevel;
        spiCsN    = 1'b1;
        budget    = ResetCycles;
        fd = $fopen(DataFile, "r");                 // First pass sizes the run limit
        if (fd == 0) begin
            $display("Cannot open the test data file %0s", DataFile);
            otherErrors++;
        end else begin
            readOp(fd, op, arg, value, testName);
            while (op != OpNone) begin
                case (op)
                    OpWrite: budget += WriteBudget;
                    OpRead:  budget += ReadBudget;
                    OpPin:   budget += 1;
                    default: budget += int'(arg) * WdtTickCycles;
                endcase
                readOp(fd, op, arg, value, testName);
            end
            $fclose(fd);
        end
        cycleLimit = 2 * budget;
        repeat (ResetCycles) clockStep();
        rstN = 1'b1;
        fd = $fopen(DataFile, "r");
        if (fd != 0) begin
            readOp(fd, op, arg, value, testName);
            while (op != OpNone) begin
                case (op)
                    OpWrite: busCycle(1'b1, arg, value[7:0], testName, rdByte);
                    OpRead: begin
                        busCycle(1'b0, arg, 8'h00, testName, rdByte);
                        compareValue(testName, value, 16'(rdByte));
                    end
                    OpPin: checkPin(arg, value, testName);
                    default: begin
                        repeat (int'(arg) * WdtTickCycles) begin
                            clockStep();
                            driveBus(1'b1, LpcTarIdle);
                        end
                    end
                endcase
                readOp(fd, op, arg, value, testName);
            end
            $fclose(fd);
        end
        $display("Value errors: %0d, other errors: %0d", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/boardCpldTestdata.txt ====
// op    addr/pin  value  name      (all numbers hex)
// write and read take a 16-bit I/O address, pin takes 0 postCode 1 intN 2 flash, wait takes ticks
pin   0000 0000 resetPost
pin   0001 0001 resetIntN
pin   0002 0001 resetFlash
write 0A80 003C postWrite
pin   0000 003C postPin
read  0A80 003C postRead
write 0B80 00A5 foreignPage
pin   0000 003C foreignKeep
read  0A01 0006 ctrlReset
write 0A01 0001 swapWrite
pin   0002 0000 swapFlash
read  0A01 0003 ctrlSwapped
write 0A01 0000 swapBack
pin   0002 0001 swapBackFlash
write 0A09 0002 maskOn
read  0A09 0002 maskRead
write 0A02 0003 wdtArm
wait  0004 0000 wdtRun
pin   0002 0000 wdtFlash
pin   0001 0000 wdtIntN
read  0A09 0003 intPending
read  0A01 0003 ctrlAfterWdt
write 0A09 0003 intClear
pin   0001 0001 intCleared
read  0A09 0002 intReadClear
write 0A02 0003 wdtArmAgain
write 0A02 0000 wdtStop
wait  0005 0000 wdtIdle
pin   0002 0000 noSwap
pin   0001 0001 noInt
read  0A09 0002 noPending

// ==== boardCpld.f ====
logic/lpcPkg.sv
logic/regPkg.sv
logic/regBusIf.sv
logic/lpcTarget.sv
logic/cpldRegs.sv
logic/biosWatchdog.sv
logic/biosSwitch.sv
logic/boardCpld.sv
test/boardCpldTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module boardCpldTb \
    -f boardCpld.f -o simv \
    && ./obj_dir/simv > sim.log 2>&1 \
    || { echo "Build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx "ALL TESTS PASSED" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
